/* ids_lite.f */
src/ids_pkg.sv
src/word_fifo.sv
src/header_parser.sv
src/flow_table.sv
src/ids_top.sv
tb/ids_tb_assert.sv
tb/ids_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ids_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f ids_lite.f --top-module ids_tb -o ids_tb_sim \
	&& ./obj_dir/ids_tb_sim \
	|| exit 1

/* tb/ids_tb.sv */
`timescale 1ns/1ps

module ids_tb;

	localparam int NUM_PACKETS = 40;
	localparam int TIMEOUT_CYCLES = NUM_PACKETS * 9 * 4 + 2000;

	logic clk;
	logic reset;
	ids_pkg::bus_word_t in_word;
	logic in_wr;
	logic in_rdy;
	ids_pkg::bus_word_t out_word;
	logic out_wr;
	logic out_rdy;
	logic ft_wr;
	ids_pkg::ft_write_t ft_write;
	ids_pkg::lookup_rsp_t rsp;
	logic rsp_valid;
	logic [ids_pkg::FT_ADDR_WIDTH-1:0] cnt_addr;
	logic [ids_pkg::COUNT_WIDTH-1:0] cnt_data;
	logic [ids_pkg::COUNT_WIDTH-1:0] num_packets_in;
	logic [ids_pkg::COUNT_WIDTH-1:0] num_matches;

	// table as the host programmed it
	logic [ids_pkg::IP_WIDTH-1:0]    tb_ip [ids_pkg::FT_DEPTH];
	logic [ids_pkg::FT_DEPTH-1:0]    tb_valid;
	int hit_tally [ids_pkg::FT_DEPTH];
	int entry_addr [6] = '{1, 3, 4, 7, 9, 12};

	int exp_rsp_count = 0;
	int rsp_count = 0;
	int cycles = 0;
	logic stim_done = 1'b0;

	ids_top ids_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) begin
			rsp_count <= 0;
		end else if (rsp_valid) begin
			rsp_count <= rsp_count + 1;
		end
	end

	// random back-pressure while traffic runs
	always @(negedge clk) begin
		if (!reset && !stim_done) begin
			out_rdy = ($urandom_range(3) != 0);
		end else begin
			out_rdy = 1'b1;
		end
	end

	// failed assertions and the timeout end the run
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (ids_top_i.chk.fail_count != 0 || cycles > TIMEOUT_CYCLES) begin
			if (cycles > TIMEOUT_CYCLES) begin
				$display("timeout after %0d cycles", cycles);
			end else begin
				$display("an assertion in the bound checker failed");
			end
			$display("SIMULATION FAILED");
			$fatal(1, "run stopped");
		end
	end

	function automatic int find_entry(input logic [ids_pkg::IP_WIDTH-1:0] ip);
		int idx;
		idx = -1;
		for (int i = ids_pkg::FT_DEPTH - 1; i >= 0; i--) begin
			if (tb_valid[i] && tb_ip[i] == ip) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic program_table();
		logic [ids_pkg::IP_WIDTH-1:0] ip;
		for (int e = 0; e < 6; e++) begin
			ip = (e == 4) ? tb_ip[entry_addr[2]] : $urandom;  // duplicate of entry 4
			@(negedge clk);
			ft_wr = 1'b1;
			ft_write.addr = entry_addr[e][ids_pkg::FT_ADDR_WIDTH-1:0];
			ft_write.ip = ip;
			ft_write.action = ids_pkg::NUM_ACTIONS'(e + 5);
			tb_ip[entry_addr[e]] = ip;
			tb_valid[entry_addr[e]] = 1'b1;
		end
		@(negedge clk);
		ft_wr = 1'b0;
	endtask

	task automatic put_word(input ids_pkg::bus_word_t w);
		@(negedge clk);
		while (!in_rdy) begin
			in_wr = 1'b0;
			@(negedge clk);
		end
		in_word = w;
		in_wr = 1'b1;
	endtask

	task automatic send_packet();
		int len;
		int idx;
		logic [ids_pkg::IP_WIDTH-1:0] ip;
		ids_pkg::bus_word_t w;
		len = 3 + $urandom_range(6);
		if ($urandom_range(1) == 1) begin
			ip = tb_ip[entry_addr[$urandom_range(5)]];
		end else begin
			ip = $urandom;
		end
		for (int i = 0; i < len; i++) begin
			w.ctrl = (i == 0) ? 8'hff : ((i == len - 1) ? 8'h01 : 8'h00);
			w.data = {$urandom, $urandom};
			if (i == ids_pkg::IP_WORD_INDEX) begin
				w.data[ids_pkg::IP_LSB +: ids_pkg::IP_WIDTH] = ip;
			end
			put_word(w);
		end
		if (len > ids_pkg::IP_WORD_INDEX) begin
			exp_rsp_count++;
			idx = find_entry(ip);
			if (idx >= 0) begin
				hit_tally[idx]++;
			end
		end
	endtask

	task automatic read_counters();
		for (int a = 0; a < ids_pkg::FT_DEPTH; a++) begin
			@(negedge clk);
			cnt_addr = ids_pkg::FT_ADDR_WIDTH'(a);
			@(negedge clk);
			if (cnt_data != 32'(hit_tally[a])) begin
				$display("Error: hit_count[%0d] expected %0d actual %0d",
					a, hit_tally[a], cnt_data);
				$display("SIMULATION FAILED");
				$fatal(1, "hit counter readback mismatch");
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		in_word = '0;
		in_wr = 1'b0;
		out_rdy = 1'b1;
		ft_wr = 1'b0;
		ft_write = '0;
		cnt_addr = '0;
		tb_valid = '0;
		for (int i = 0; i < ids_pkg::FT_DEPTH; i++) begin
			hit_tally[i] = 0;
			tb_ip[i] = '0;
		end
		void'($urandom(69));

		repeat (16) @(negedge clk);
		reset = 1'b0;

		program_table();
		for (int p = 0; p < NUM_PACKETS; p++) begin
			send_packet();
		end
		@(negedge clk);
		in_wr = 1'b0;
		stim_done = 1'b1;

		// drain
		while (rsp_count != exp_rsp_count || num_packets_in != NUM_PACKETS) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);

		read_counters();

		if (ids_top_i.chk.fail_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "assertion failure in the bound checker");
		end
	end

endmodule

/* tb/ids_tb_assert.sv */
`timescale 1ns/1ps

module ids_tb_assert (
	input logic                                 clk,
	input logic                                 reset,
	input ids_pkg::bus_word_t                   in_word,
	input logic                                 in_wr,
	input logic                                 in_rdy,
	input ids_pkg::bus_word_t                   out_word,
	input logic                                 out_wr,
	input logic                                 out_rdy,
	input logic                                 ft_wr,
	input ids_pkg::ft_write_t                   ft_write,
	input ids_pkg::lookup_rsp_t                 rsp,
	input logic                                 rsp_valid,
	input logic [ids_pkg::COUNT_WIDTH-1:0]      num_packets_in,
	input logic [ids_pkg::COUNT_WIDTH-1:0]      num_matches
);

	ids_pkg::bus_word_t word_mem [1024];       // accepted input words
	logic [9:0] word_wr;
	logic [9:0] word_rd;

	logic [ids_pkg::IP_WIDTH-1:0]  req_ip_mem [256];
	logic [ids_pkg::SEQ_WIDTH-1:0] req_seq_mem [256];
	logic [7:0] req_wr_i;
	logic [7:0] req_rd_i;

	// table mirror
	logic [ids_pkg::IP_WIDTH-1:0]    mir_ip [ids_pkg::FT_DEPTH];
	logic [ids_pkg::NUM_ACTIONS-1:0] mir_act [ids_pkg::FT_DEPTH];
	logic [ids_pkg::FT_DEPTH-1:0]    mir_valid;

	logic in_pkt;
	int in_idx;
	logic [ids_pkg::SEQ_WIDTH-1:0] next_seq;
	logic out_pkt;
	int ends_fwd;
	int match_tally;
	logic reset_d;

	int fail_count = 0;  // read by the testbench top

	ids_pkg::bus_word_t exp_word;
	ids_pkg::lookup_rsp_t exp_rsp;
	logic word_avail;
	logic req_avail;
	logic out_end;

	assign exp_word = word_mem[word_rd];
	assign word_avail = (word_rd != word_wr);
	assign req_avail = (req_rd_i != req_wr_i);
	assign out_end = out_wr && out_pkt && (out_word.ctrl != '0);

	// lowest matching entry wins
	always_comb begin
		exp_rsp.seq = req_seq_mem[req_rd_i];
		exp_rsp.match = 1'b0;
		exp_rsp.action = '0;
		for (int i = ids_pkg::FT_DEPTH - 1; i >= 0; i--) begin
			if (mir_valid[i] && mir_ip[i] == req_ip_mem[req_rd_i]) begin
				exp_rsp.match = 1'b1;
				exp_rsp.action = mir_act[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		reset_d <= reset;
		if (reset) begin
			word_wr <= '0;
			word_rd <= '0;
			req_wr_i <= '0;
			req_rd_i <= '0;
			mir_valid <= '0;
			in_pkt <= 1'b0;
			in_idx <= 0;
			next_seq <= '0;
			out_pkt <= 1'b0;
			ends_fwd <= 0;
			match_tally <= 0;
		end else begin
			if (ft_wr) begin
				mir_ip[ft_write.addr] <= ft_write.ip;
				mir_act[ft_write.addr] <= ft_write.action;
				mir_valid[ft_write.addr] <= 1'b1;
			end
			if (in_wr && in_rdy) begin
				word_mem[word_wr] <= in_word;
				word_wr <= word_wr + 1'b1;
				if (!in_pkt) begin
					if (in_word.ctrl != '0) begin
						in_pkt <= 1'b1;
						in_idx <= 1;
					end
				end else begin
					if (in_idx == ids_pkg::IP_WORD_INDEX) begin
						req_ip_mem[req_wr_i] <= in_word.data[ids_pkg::IP_LSB +: ids_pkg::IP_WIDTH];
						req_seq_mem[req_wr_i] <= next_seq;
						req_wr_i <= req_wr_i + 1'b1;
						next_seq <= next_seq + 1'b1;
					end
					if (in_word.ctrl != '0) begin
						in_pkt <= 1'b0;  // end word
						in_idx <= 0;
					end else if (in_idx <= ids_pkg::IP_WORD_INDEX) begin
						in_idx <= in_idx + 1;
					end
				end
			end
			if (out_wr) begin
				word_rd <= word_rd + 1'b1;
				if (out_word.ctrl != '0) begin
					out_pkt <= !out_pkt;
				end
				if (out_end) begin
					ends_fwd <= ends_fwd + 1;
				end
			end
			if (rsp_valid) begin
				req_rd_i <= req_rd_i + 1'b1;
				if (exp_rsp.match) begin
					match_tally <= match_tally + 1;
				end
			end
		end
	end

	a_after_reset: assert property (@(posedge clk) (reset_d && !reset) |->
		(in_rdy && !out_wr && !rsp_valid && num_packets_in == '0 && num_matches == '0))
		else begin
			$error(
				"Error: after_reset expected rdy=1 wr=0 rsp=0 pkts=0 mt=0 actual %0b %0b %0b %0d %0d",
				in_rdy, out_wr, rsp_valid, num_packets_in, num_matches);
			fail_count++;
		end

	a_out_word: assert property (@(posedge clk) disable iff (reset)
		out_wr |-> (word_avail && out_word == exp_word))
		else begin
			$error("Error: out_word expected %h actual %h (pending=%0b)",
				exp_word, out_word, word_avail);
			fail_count++;
		end

	a_out_stall: assert property (@(posedge clk) disable iff (reset)
		!out_rdy |=> !out_wr)
		else begin
			$error("Error: out_stall expected out_wr 0 actual 1");
			fail_count++;
		end

	a_rsp: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> (req_avail && rsp == exp_rsp))
		else begin
			$error("Error: lookup_rsp expected %h actual %h (pending=%0b)",
				exp_rsp, rsp, req_avail);
			fail_count++;
		end

	a_pkts: assert property (@(posedge clk) disable iff (reset || reset_d)
		num_packets_in == 32'(ends_fwd) + 32'(out_end))
		else begin
			$error("Error: num_packets_in expected %0d actual %0d",
				ends_fwd + int'(out_end), num_packets_in);
			fail_count++;
		end

	a_matches: assert property (@(posedge clk) disable iff (reset || reset_d)
		num_matches == 32'(match_tally) + 32'(rsp_valid && exp_rsp.match))
		else begin
			$error("Error: num_matches expected %0d actual %0d",
				match_tally + int'(rsp_valid && exp_rsp.match), num_matches);
			fail_count++;
		end

endmodule

bind ids_top ids_tb_assert chk (.*);

/* src/ids_top.sv */
`timescale 1ns/1ps

module ids_top (
	input  logic                                 clk,
	input  logic                                 reset,

	input  ids_pkg::bus_word_t                   in_word,
	input  logic                                 in_wr,
	output logic                                 in_rdy,

	output ids_pkg::bus_word_t                   out_word,
	output logic                                 out_wr,
	input  logic                                 out_rdy,

	input  logic                                 ft_wr,
	input  ids_pkg::ft_write_t                   ft_write,

	output ids_pkg::lookup_rsp_t                 rsp,
	output logic                                 rsp_valid,

	input  logic [ids_pkg::FT_ADDR_WIDTH-1:0]    cnt_addr,
	output logic [ids_pkg::COUNT_WIDTH-1:0]      cnt_data,
	output logic [ids_pkg::COUNT_WIDTH-1:0]      num_packets_in,
	output logic [ids_pkg::COUNT_WIDTH-1:0]      num_matches
);

	ids_pkg::bus_word_t   in_head;
	logic                 in_empty;
	logic                 in_nearly_full;
	logic                 in_rd;

	ids_pkg::lookup_req_t req_in;
	ids_pkg::lookup_req_t req_head;
	logic                 req_wr;
	logic                 req_rd;
	logic                 req_empty;
	logic                 req_full;

	assign in_rdy = !in_nearly_full;

	word_fifo #(
		.payload_t   (ids_pkg::bus_word_t),
		.DEPTH_BITS  (ids_pkg::FIFO_DEPTH_BITS)
	) in_fifo (
		.clk         (clk),
		.reset       (reset),
		.din         (in_word),
		.wr_en       (in_wr),
		.rd_en       (in_rd),
		.dout        (in_head),
		.empty       (in_empty),
		.full        (),
		.nearly_full (in_nearly_full)
	);

	header_parser parser (
		.clk            (clk),
		.reset          (reset),
		.head           (in_head),
		.empty          (in_empty),
		.rd_en          (in_rd),
		.out_rdy        (out_rdy),
		.out_word       (out_word),
		.out_wr         (out_wr),
		.req_full       (req_full),
		.req            (req_in),
		.req_wr         (req_wr),
		.num_packets_in (num_packets_in)
	);

	word_fifo #(
		.payload_t   (ids_pkg::lookup_req_t),
		.DEPTH_BITS  (ids_pkg::FIFO_DEPTH_BITS)
	) req_fifo (
		.clk         (clk),
		.reset       (reset),
		.din         (req_in),
		.wr_en       (req_wr),
		.rd_en       (req_rd),
		.dout        (req_head),
		.empty       (req_empty),
		.full        (req_full),
		.nearly_full ()
	);

	flow_table table_i (
		.clk         (clk),
		.reset       (reset),
		.ft_wr       (ft_wr),
		.ft_write    (ft_write),
		.req         (req_head),
		.req_empty   (req_empty),
		.req_rd      (req_rd),
		.rsp         (rsp),
		.rsp_valid   (rsp_valid),
		.cnt_addr    (cnt_addr),
		.cnt_data    (cnt_data),
		.num_matches (num_matches)
	);

endmodule

/* src/flow_table.sv */
`timescale 1ns/1ps

module flow_table (
	input  logic                                 clk,
	input  logic                                 reset,

	// host programming
	input  logic                                 ft_wr,
	input  ids_pkg::ft_write_t                   ft_write,

	// request fifo head
	input  ids_pkg::lookup_req_t                 req,
	input  logic                                 req_empty,
	output logic                                 req_rd,

	output ids_pkg::lookup_rsp_t                 rsp,
	output logic                                 rsp_valid,

	// hit counter readback
	input  logic [ids_pkg::FT_ADDR_WIDTH-1:0]    cnt_addr,
	output logic [ids_pkg::COUNT_WIDTH-1:0]      cnt_data,

	output logic [ids_pkg::COUNT_WIDTH-1:0]      num_matches
);

	logic [ids_pkg::IP_WIDTH-1:0]    ft_ip [ids_pkg::FT_DEPTH];
	logic [ids_pkg::NUM_ACTIONS-1:0] ft_action [ids_pkg::FT_DEPTH];
	logic [ids_pkg::FT_DEPTH-1:0]    ft_valid;

	logic [ids_pkg::COUNT_WIDTH-1:0] hit_cnt [ids_pkg::FT_DEPTH];

	logic [ids_pkg::FT_DEPTH-1:0]      hit_vec;
	logic                              hit;
	logic [ids_pkg::FT_ADDR_WIDTH-1:0] hit_idx;

	// one lookup per cycle while requests are queued
	assign req_rd = !req_empty;

	// compare every entry at once
	always_comb begin
		for (int i = 0; i < ids_pkg::FT_DEPTH; i++) begin
			hit_vec[i] = ft_valid[i] && (ft_ip[i] == req.ip);
		end
	end

	// lowest index wins, so scan downwards and let the last hit stick
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = ids_pkg::FT_DEPTH - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				hit = 1'b1;
				hit_idx = ids_pkg::FT_ADDR_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ft_wr) begin
			ft_ip[ft_write.addr] <= ft_write.ip;
			ft_action[ft_write.addr] <= ft_write.action;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ft_valid <= '0;
		end else if (ft_wr) begin
			ft_valid[ft_write.addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_rd) begin
			rsp.seq <= req.seq;
			rsp.match <= hit;
			rsp.action <= hit ? ft_action[hit_idx] : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= req_rd;
		end
	end

	// counters step on the same edge that raises rsp_valid
	always_ff @(posedge clk) begin
		if (reset) begin
			num_matches <= '0;
			for (int i = 0; i < ids_pkg::FT_DEPTH; i++) begin
				hit_cnt[i] <= '0;
			end
		end else if (req_rd && hit) begin
			num_matches <= num_matches + 1'b1;
			hit_cnt[hit_idx] <= hit_cnt[hit_idx] + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		cnt_data <= hit_cnt[cnt_addr];  // host holds cnt_addr
	end

endmodule

/* src/header_parser.sv */
`timescale 1ns/1ps

module header_parser (
	input  logic                                 clk,
	input  logic                                 reset,

	// input fifo head
	input  ids_pkg::bus_word_t                   head,
	input  logic                                 empty,
	output logic                                 rd_en,

	// forwarded stream
	input  logic                                 out_rdy,
	output ids_pkg::bus_word_t                   out_word,
	output logic                                 out_wr,

	// lookup requests
	input  logic                                 req_full,
	output ids_pkg::lookup_req_t                 req,
	output logic                                 req_wr,

	output logic [ids_pkg::COUNT_WIDTH-1:0]      num_packets_in
);

	typedef enum logic {
		IDLE,
		IN_PKT
	} state_t;

	state_t state;

	// index of the head word within its packet, saturates past the ip word
	logic [$clog2(ids_pkg::IP_WORD_INDEX+2)-1:0] word_cnt;
	logic [ids_pkg::SEQ_WIDTH-1:0] seq;

	logic is_ctrl;
	logic ip_word;
	logic stall;
	logic pop;

	assign is_ctrl = (head.ctrl != '0);
	assign ip_word = (state == IN_PKT) && (word_cnt == ids_pkg::IP_WORD_INDEX);

	// hold the ip word until the request fifo has room
	assign stall = ip_word && req_full;
	assign pop = !empty && out_rdy && !stall;

	assign rd_en = pop;

	// request goes out together with the pop of the ip word
	assign req_wr = pop && ip_word;
	assign req.seq = seq;
	assign req.ip = head.data[ids_pkg::IP_LSB +: ids_pkg::IP_WIDTH];

	always_ff @(posedge clk) begin
		if (pop) begin
			out_word <= head;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_wr <= 1'b0;
		end else begin
			out_wr <= pop;  // fixed one cycle from pop
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			seq <= '0;
		end else if (req_wr) begin
			seq <= seq + 1'b1;
		end
	end

	// packet framing
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			word_cnt <= '0;
			num_packets_in <= '0;
		end else if (pop) begin
			case (state)
				IDLE: begin
					// body words outside a packet are passed on and ignored
					if (is_ctrl) begin
						state <= IN_PKT;
						word_cnt <= word_cnt + 1'b1;
					end
				end
				IN_PKT: begin
					if (is_ctrl) begin
						// end word
						state <= IDLE;
						word_cnt <= '0;
						num_packets_in <= num_packets_in + 1'b1;
					end else if (word_cnt <= ids_pkg::IP_WORD_INDEX) begin
						word_cnt <= word_cnt + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
					word_cnt <= '0;
				end
			endcase
		end
	end

endmodule

/* src/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
	parameter type payload_t = ids_pkg::bus_word_t,
	parameter int DEPTH_BITS = ids_pkg::FIFO_DEPTH_BITS
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t din,
	input  logic     wr_en,
	input  logic     rd_en,
	output payload_t dout,
	output logic     empty,
	output logic     full,
	output logic     nearly_full
);

	payload_t mem [0:(2**DEPTH_BITS)-1];

	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS:0] count;   // one extra bit to tell full from empty

	logic do_wr;
	logic do_rd;

	// writes to a full fifo and reads from an empty one are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head word shows without a read
	assign dout = mem[rd_ptr];

	assign empty = (count == '0);
	assign full = count[DEPTH_BITS];
	// full, or only one slot left
	assign nearly_full = count[DEPTH_BITS] || (&count[DEPTH_BITS-1:0]);

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1; // pointers wrap on their own
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({do_wr, do_rd})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;  // idle or push and pop together
				end
			endcase
		end
	end

endmodule

/* src/ids_pkg.sv */
package ids_pkg;

	// bus word layout
	localparam int DATA_WIDTH = 64;
	localparam int CTRL_WIDTH = 8;

	// where the source ip sits inside a packet
	localparam int IP_WIDTH = 32;
	localparam int IP_WORD_INDEX = 4;   // counted from the first word
	localparam int IP_LSB = 16;

	// flow table
	localparam int FT_DEPTH = 16;
	localparam int FT_ADDR_WIDTH = 4;
	localparam int NUM_ACTIONS = 4;

	localparam int SEQ_WIDTH = 3;       // wraps at 8
	localparam int COUNT_WIDTH = 32;
	localparam int FIFO_DEPTH_BITS = 2; // 4 entries

	typedef struct packed {
		logic [CTRL_WIDTH-1:0] ctrl;
		logic [DATA_WIDTH-1:0] data;
	} bus_word_t;

	typedef struct packed {
		logic [SEQ_WIDTH-1:0] seq;
		logic [IP_WIDTH-1:0] ip;
	} lookup_req_t;

	typedef struct packed {
		logic [SEQ_WIDTH-1:0] seq;
		logic match;
		logic [NUM_ACTIONS-1:0] action;
	} lookup_rsp_t;

	// host write into one table entry
	typedef struct packed {
		logic [FT_ADDR_WIDTH-1:0] addr;
		logic [IP_WIDTH-1:0] ip;
		logic [NUM_ACTIONS-1:0] action;
	} ft_write_t;

endpackage
